// File: rtl/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int XLEN       = 32;
    localparam int OPC_W      = 17;
    localparam int REG_ADDR_W = 5;

    // major opcodes, opcode[16:10]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct3, opcode[9:7]
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_LB      = 3'b000;
    localparam logic [2:0] F3_LH      = 3'b001;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_LBU     = 3'b100;
    localparam logic [2:0] F3_LHU     = 3'b101;
    localparam logic [2:0] F3_SB      = 3'b000;
    localparam logic [2:0] F3_SH      = 3'b001;
    localparam logic [2:0] F3_SW      = 3'b010;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;
    localparam logic [2:0] F3_JALR    = 3'b000;
    localparam logic [2:0] F3_PRIV    = 3'b000;

    // funct7, opcode[6:0]
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    localparam logic [3:0] EXC_ILLEGAL = 4'd2;
    localparam logic [3:0] EXC_BREAK   = 4'd3;
    localparam logic [3:0] EXC_ECALL   = 4'd11;

    localparam logic [3:0] STRB_B = 4'b0001;
    localparam logic [3:0] STRB_H = 4'b0011;
    localparam logic [3:0] STRB_W = 4'b1111;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [OPC_W-1:0]      opcode;     // {major, funct3, funct7}
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [XLEN-1:0]       rs1_data;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
    } issue_t;

    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } reg_wr_t;

    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       addr;
        logic [3:0]            strb;
        logic                  is_signed;
    } mem_rd_t;

    typedef struct packed {
        logic            en;
        logic [XLEN-1:0] addr;
        logic [3:0]      strb;
        logic [XLEN-1:0] data;
    } mem_wr_t;

    typedef struct packed {
        logic            taken;
        logic            not_taken;
        logic [XLEN-1:0] target;
    } jmp_t;

    typedef struct packed {
        logic       en;
        logic [3:0] code;
    } exc_t;

    // addi x0,x0,0 with valid low
    function automatic issue_t nop_issue();
        issue_t n;
        n        = '0;
        n.opcode = {OPC_OP_IMM, F3_ADD_SUB, F7_BASE};
        return n;
    endfunction

endpackage

`default_nettype wire

// File: rtl/exec_issue_reg.sv
`timescale 1ns/1ps
`default_nettype none

module exec_issue_reg (
    input  wire              CLK,
    input  wire              arst_n,
    input  wire              flush,
    input  wire              stall,
    input  wire              mmu_wait,
    input  exec_pkg::issue_t issue_in,
    output exec_pkg::issue_t cur
);
    import exec_pkg::*;

    issue_t nxt;
    logic   load;

    // flush beats mmu_wait, mmu_wait beats stall
    always_comb begin
        load = 1'b1;
        nxt  = issue_in;
        if (flush) begin
            nxt = nop_issue();
        end else if (mmu_wait) begin
            load = 1'b0;                // freeze
        end else if (stall) begin
            nxt = nop_issue();          // bubble
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            cur <= nop_issue();
        end else if (load) begin
            cur <= nxt;
        end
    end

endmodule

`default_nettype wire

// File: rtl/exec_int_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_int_unit (
    input  exec_pkg::issue_t  cur,
    output exec_pkg::reg_wr_t reg_wr
);
    import exec_pkg::*;

    logic [XLEN-1:0]        imm_i;
    logic [XLEN-1:0]        imm_u;
    logic signed [XLEN-1:0] rs1_s;
    logic signed [XLEN-1:0] rs2_s;
    logic signed [XLEN-1:0] imm_s;
    logic [XLEN-1:0]        result;
    logic                   hit;

    assign imm_i = {{(XLEN-12){cur.imm[11]}}, cur.imm[11:0]};
    assign imm_u = {cur.imm[31:12], 12'b0};
    assign rs1_s = cur.rs1_data;
    assign rs2_s = cur.rs2_data;
    assign imm_s = imm_i;

    always_comb begin
        hit    = 1'b1;
        result = '0;
        casez (cur.opcode)
            {OPC_OP, F3_ADD_SUB, F7_BASE}:   result = cur.rs1_data + cur.rs2_data;
            {OPC_OP, F3_ADD_SUB, F7_ALT}:    result = cur.rs1_data - cur.rs2_data;
            {OPC_OP, F3_AND, F7_BASE}:       result = cur.rs1_data & cur.rs2_data;
            {OPC_OP, F3_OR, F7_BASE}:        result = cur.rs1_data | cur.rs2_data;
            {OPC_OP, F3_XOR, F7_BASE}:       result = cur.rs1_data ^ cur.rs2_data;
            {OPC_OP, F3_SLL, F7_BASE}:       result = cur.rs1_data << cur.rs2_data[4:0];
            {OPC_OP, F3_SRL_SRA, F7_BASE}:   result = cur.rs1_data >> cur.rs2_data[4:0];
            {OPC_OP, F3_SRL_SRA, F7_ALT}:    result = rs1_s >>> cur.rs2_data[4:0];
            {OPC_OP, F3_SLT, F7_BASE}: begin
                result = {{(XLEN-1){1'b0}}, rs1_s < rs2_s};
            end
            {OPC_OP, F3_SLTU, F7_BASE}: begin
                result = {{(XLEN-1){1'b0}}, cur.rs1_data < cur.rs2_data};
            end
            // immediate forms ignore funct7 except for shifts
            {OPC_OP_IMM, F3_ADD_SUB, 7'b???????}: result = cur.rs1_data + imm_i;
            {OPC_OP_IMM, F3_AND, 7'b???????}:     result = cur.rs1_data & imm_i;
            {OPC_OP_IMM, F3_OR, 7'b???????}:      result = cur.rs1_data | imm_i;
            {OPC_OP_IMM, F3_XOR, 7'b???????}:     result = cur.rs1_data ^ imm_i;
            {OPC_OP_IMM, F3_SLL, F7_BASE}:        result = cur.rs1_data << cur.imm[4:0];
            {OPC_OP_IMM, F3_SRL_SRA, F7_BASE}:    result = cur.rs1_data >> cur.imm[4:0];
            {OPC_OP_IMM, F3_SRL_SRA, F7_ALT}:     result = rs1_s >>> cur.imm[4:0];
            {OPC_OP_IMM, F3_SLT, 7'b???????}: begin
                result = {{(XLEN-1){1'b0}}, rs1_s < imm_s};
            end
            {OPC_OP_IMM, F3_SLTU, 7'b???????}: begin
                result = {{(XLEN-1){1'b0}}, cur.rs1_data < imm_i};
            end
            {OPC_LUI, 10'b??????????}:            result = imm_u;
            {OPC_AUIPC, 10'b??????????}:          result = cur.pc + imm_u;
            {OPC_JAL, 10'b??????????}:            result = cur.pc + 32'd4;   // link
            {OPC_JALR, F3_JALR, 7'b???????}:      result = cur.pc + 32'd4;
            default: begin
                hit = 1'b0;
            end
        endcase
    end

    assign reg_wr.en   = hit;
    assign reg_wr.rd   = hit ? cur.rd : '0;
    assign reg_wr.data = result;

endmodule

`default_nettype wire

// File: rtl/exec_lsu_addr.sv
`timescale 1ns/1ps
`default_nettype none

module exec_lsu_addr (
    input  exec_pkg::issue_t  cur,
    output exec_pkg::mem_rd_t mem_rd,
    output exec_pkg::mem_wr_t mem_wr
);
    import exec_pkg::*;

    logic [XLEN-1:0] ea;

    assign ea = cur.rs1_data + {{(XLEN-12){cur.imm[11]}}, cur.imm[11:0]};

    always_comb begin
        mem_rd = '0;
        case (cur.opcode[16:7])
            {OPC_LOAD, F3_LB}:  mem_rd = '{1'b1, cur.rd, ea, STRB_B, 1'b1};
            {OPC_LOAD, F3_LBU}: mem_rd = '{1'b1, cur.rd, ea, STRB_B, 1'b0};
            {OPC_LOAD, F3_LH}:  mem_rd = '{1'b1, cur.rd, ea, STRB_H, 1'b1};
            {OPC_LOAD, F3_LHU}: mem_rd = '{1'b1, cur.rd, ea, STRB_H, 1'b0};
            {OPC_LOAD, F3_LW}:  mem_rd = '{1'b1, cur.rd, ea, STRB_W, 1'b0};  // no sign flag on lw
            default: begin
                mem_rd = '0;
            end
        endcase
    end

    // store data goes out unshifted, the strobe gives the width
    always_comb begin
        mem_wr = '0;
        case (cur.opcode[16:7])
            {OPC_STORE, F3_SB}: mem_wr = '{1'b1, ea, STRB_B, cur.rs2_data};
            {OPC_STORE, F3_SH}: mem_wr = '{1'b1, ea, STRB_H, cur.rs2_data};
            {OPC_STORE, F3_SW}: mem_wr = '{1'b1, ea, STRB_W, cur.rs2_data};
            default: begin
                mem_wr = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/exec_branch.sv
`timescale 1ns/1ps
`default_nettype none

module exec_branch (
    input  exec_pkg::issue_t cur,
    output exec_pkg::jmp_t   jmp
);
    import exec_pkg::*;

    logic [6:0]             major;
    logic [2:0]             f3;
    logic signed [XLEN-1:0] rs1_s;
    logic signed [XLEN-1:0] rs2_s;
    logic [XLEN-1:0]        imm_b;
    logic [XLEN-1:0]        imm_j;
    logic [XLEN-1:0]        jalr_sum;
    logic                   cond;
    logic                   is_br;

    assign major    = cur.opcode[16:10];
    assign f3       = cur.opcode[9:7];
    assign rs1_s    = cur.rs1_data;
    assign rs2_s    = cur.rs2_data;
    assign imm_b    = {{(XLEN-13){cur.imm[12]}}, cur.imm[12:1], 1'b0};
    assign imm_j    = {{(XLEN-21){cur.imm[20]}}, cur.imm[20:1], 1'b0};
    assign jalr_sum = cur.rs1_data + {{(XLEN-12){cur.imm[11]}}, cur.imm[11:0]};

    always_comb begin
        is_br = (major == OPC_BRANCH);
        cond  = 1'b0;
        case (f3)
            F3_BEQ:  cond = cur.rs1_data == cur.rs2_data;
            F3_BNE:  cond = cur.rs1_data != cur.rs2_data;
            F3_BLT:  cond = rs1_s < rs2_s;
            F3_BGE:  cond = rs1_s >= rs2_s;
            F3_BLTU: cond = cur.rs1_data < cur.rs2_data;
            F3_BGEU: cond = cur.rs1_data >= cur.rs2_data;
            default: is_br = 1'b0;      // 010 and 011 are not branches
        endcase
    end

    always_comb begin
        jmp = '0;
        if (is_br) begin
            jmp = '{cond, !cond, cur.pc + imm_b};
        end else if (major == OPC_JAL) begin
            jmp = '{1'b1, 1'b0, cur.pc + imm_j};
        end else if (major == OPC_JALR && f3 == F3_JALR) begin
            jmp = '{1'b1, 1'b0, {jalr_sum[XLEN-1:1], 1'b0}};
        end
    end

endmodule

`default_nettype wire

// File: rtl/exec_trap.sv
`timescale 1ns/1ps
`default_nettype none

module exec_trap (
    input  exec_pkg::issue_t cur,
    input  logic             reg_wr_en,
    input  logic             mem_rd_en,
    input  logic             mem_wr_en,
    input  logic             jmp_taken,
    input  logic             jmp_not_taken,
    output exec_pkg::exc_t   exc
);
    import exec_pkg::*;

    logic is_env;
    logic claimed;

    assign is_env  = (cur.opcode == {OPC_SYSTEM, F3_PRIV, F7_BASE});
    assign claimed = reg_wr_en | mem_rd_en | mem_wr_en | jmp_taken | jmp_not_taken;

    always_comb begin
        exc = '0;
        if (is_env) begin
            exc.en   = 1'b1;
            exc.code = (cur.imm[11:0] == 12'b0) ? EXC_ECALL : EXC_BREAK;
        end else if (!claimed) begin
            // csr, fence and unknown encodings end up here
            exc.en   = 1'b1;
            exc.code = EXC_ILLEGAL;
        end
    end

endmodule

`default_nettype wire

// File: rtl/exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_top (
    input  wire                       CLK,
    input  wire                       arst_n,
    input  wire                       flush,
    input  wire                       stall,
    input  wire                       mmu_wait,
    input  exec_pkg::issue_t          issue,
    output logic                      exec_valid,
    output logic [exec_pkg::XLEN-1:0] exec_pc,
    output exec_pkg::reg_wr_t         reg_wr,
    output exec_pkg::mem_rd_t         mem_rd,
    output exec_pkg::mem_wr_t         mem_wr,
    output exec_pkg::jmp_t            jmp,
    output exec_pkg::exc_t            exc
);
    import exec_pkg::*;

    issue_t cur;    // instruction in execute

    exec_issue_reg u_issue_reg (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .flush    (flush),
        .stall    (stall),
        .mmu_wait (mmu_wait),
        .issue_in (issue),
        .cur      (cur)
    );

    exec_int_unit u_int_unit (
        .cur    (cur),
        .reg_wr (reg_wr)
    );

    exec_lsu_addr u_lsu_addr (
        .cur    (cur),
        .mem_rd (mem_rd),
        .mem_wr (mem_wr)
    );

    exec_branch u_branch (
        .cur (cur),
        .jmp (jmp)
    );

    // trap sees every unit's claim
    exec_trap u_trap (
        .cur           (cur),
        .reg_wr_en     (reg_wr.en),
        .mem_rd_en     (mem_rd.en),
        .mem_wr_en     (mem_wr.en),
        .jmp_taken     (jmp.taken),
        .jmp_not_taken (jmp.not_taken),
        .exc           (exc)
    );

    assign exec_valid = cur.valid;
    assign exec_pc    = cur.pc;

endmodule

`default_nettype wire

// File: verification/exec_props.sv
`timescale 1ns/1ps
`default_nettype none

module exec_props (
    input wire               CLK,
    input wire               arst_n,
    input wire               flush,
    input wire               exec_valid,
    input exec_pkg::mem_rd_t mem_rd,
    input exec_pkg::mem_wr_t mem_wr,
    input exec_pkg::jmp_t    jmp
);

    one_mem_op: assert property (@(posedge CLK) disable iff (!arst_n)
        !(mem_rd.en && mem_wr.en))
        else $error("mem_rd.en and mem_wr.en high in the same cycle");

    branch_outcome: assert property (@(posedge CLK) disable iff (!arst_n)
        !(jmp.taken && jmp.not_taken))
        else $error("jmp.taken and jmp.not_taken high in the same cycle");

    // flush loads the bubble at the same edge
    flush_bubble: assert property (@(posedge CLK) disable iff (!arst_n)
        flush |=> !exec_valid)
        else $error("exec_valid high one cycle after flush");

endmodule

bind exec_top exec_props u_props (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .flush      (flush),
    .exec_valid (exec_valid),
    .mem_rd     (mem_rd),
    .mem_wr     (mem_wr),
    .jmp        (jmp)
);

`default_nettype wire

// File: verification/tb_exec.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec;
    import exec_pkg::*;

    localparam int          CLK_PERIOD = 10;
    localparam int          RST_CYCLES = 16;
    localparam int          N_CYCLES   = 4000;
    localparam logic [31:0] SEED       = 32'h49178645;

    // 0001111 is fence, 1011011 is claimed by nobody
    localparam logic [6:0] MAJORS [12] = '{OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC,
        OPC_JAL, OPC_JALR, OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_SYSTEM, 7'b0001111, 7'b1011011};
    localparam logic [6:0] FUNCT7S [4] = '{F7_BASE, F7_ALT, F7_BASE, 7'b0000001};

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        reg_wr_t         rw;
        mem_rd_t         mr;
        mem_wr_t         mw;
        jmp_t            j;
        exc_t            e;
    } expect_t;

    logic            CLK;
    logic            arst_n;
    logic            flush;
    logic            stall;
    logic            mmu_wait;
    issue_t          issue;
    logic            exec_valid;
    logic [XLEN-1:0] exec_pc;
    reg_wr_t         reg_wr;
    mem_rd_t         mem_rd;
    mem_wr_t         mem_wr;
    jmp_t            jmp;
    exc_t            exc;
    issue_t          shadow;    // what the issue register should hold
    expect_t         want;
    logic            checking;
    logic [31:0]     rng;
    int              wait_left;
    int              errors;

    exec_top u_dut (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic issue_t bubble();
        issue_t b;
        b        = '0;
        b.opcode = {OPC_OP_IMM, 3'b000, F7_BASE};   // addi x0,x0,0
        return b;
    endfunction

    function automatic expect_t exec_ref(input issue_t s);
        expect_t     e;
        logic [6:0]  maj;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ii;
        logic [31:0] ea;
        logic [31:0] res;
        logic [3:0]  strb;
        logic        ok;
        logic        cond;
        e       = '0;
        maj     = s.opcode[16:10];
        f3      = s.opcode[9:7];
        f7      = s.opcode[6:0];
        a       = s.rs1_data;
        ii      = {{20{s.imm[11]}}, s.imm[11:0]};
        ea      = a + ii;
        b       = (maj == OPC_OP) ? s.rs2_data : ii;
        strb    = (f3[1:0] == 2'd0) ? STRB_B : (f3[1:0] == 2'd1) ? STRB_H : STRB_W;
        e.valid = s.valid;
        e.pc    = s.pc;
        case (f3)
            3'd0: res = (maj == OPC_OP && f7 == F7_ALT) ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = {31'b0, $signed(a) < $signed(b)};
            3'd3: res = {31'b0, a < b};
            3'd4: res = a ^ b;
            3'd5: res = (f7 == F7_ALT) ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        if (maj == OPC_OP) begin
            ok = f7 == F7_BASE || (f7 == F7_ALT && (f3 == 3'd0 || f3 == 3'd5));
        end else begin
            ok = (f3 == 3'd1) ? f7 == F7_BASE : (f3 != 3'd5 || f7 == F7_BASE || f7 == F7_ALT);
        end
        if ((maj == OPC_OP || maj == OPC_OP_IMM) && ok) e.rw = '{1'b1, s.rd, res};
        if (maj == OPC_LUI) e.rw = '{1'b1, s.rd, {s.imm[31:12], 12'b0}};
        if (maj == OPC_AUIPC) e.rw = '{1'b1, s.rd, s.pc + {s.imm[31:12], 12'b0}};
        if (maj == OPC_JAL) begin
            e.rw = '{1'b1, s.rd, s.pc + 32'd4};
            e.j  = '{1'b1, 1'b0, s.pc + {{11{s.imm[20]}}, s.imm[20:1], 1'b0}};
        end
        if (maj == OPC_JALR && f3 == 3'd0) begin
            e.rw = '{1'b1, s.rd, s.pc + 32'd4};
            e.j  = '{1'b1, 1'b0, {ea[31:1], 1'b0}};
        end
        if (maj == OPC_LOAD && f3 != 3'd3 && f3 < 3'd6) e.mr = '{1'b1, s.rd, ea, strb, f3 < 3'd2};
        if (maj == OPC_STORE && f3 < 3'd3) e.mw = '{1'b1, ea, strb, s.rs2_data};
        if (maj == OPC_BRANCH && f3[2:1] != 2'b01) begin
            case (f3)
                3'd0: cond = a == s.rs2_data;
                3'd1: cond = a != s.rs2_data;
                3'd4: cond = $signed(a) < $signed(s.rs2_data);
                3'd5: cond = $signed(a) >= $signed(s.rs2_data);
                3'd6: cond = a < s.rs2_data;
                default: cond = a >= s.rs2_data;
            endcase
            e.j = '{cond, !cond, s.pc + {{19{s.imm[12]}}, s.imm[12:1], 1'b0}};
        end
        if (s.opcode == {OPC_SYSTEM, 10'b0}) begin
            e.e = '{1'b1, (s.imm[11:0] == 12'd0) ? EXC_ECALL : EXC_BREAK};
        end else if (!(e.rw.en || e.mr.en || e.mw.en || e.j.taken || e.j.not_taken)) begin
            e.e = '{1'b1, EXC_ILLEGAL};
        end
        return e;
    endfunction

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp_v);
        assert (got === exp_v) else begin
            errors++;
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp_v);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic drive_random();
        issue_t n;
        rng      = xorshift32(rng);
        n.valid  = 1'b1;
        n.opcode = {MAJORS[rng[3:0] % 4'd12], rng[6:4], FUNCT7S[rng[8:7]]};
        if (n.opcode[16:10] == OPC_SYSTEM && rng[9]) begin
            n.opcode[9:0] = '0;                     // ecall or ebreak
        end
        n.rd  = rng[14:10];
        n.rs1 = rng[19:15];
        n.rs2 = rng[24:20];
        flush = rng[31:26] == 6'd0;
        stall = rng[31:26] == 6'd1;
        if (wait_left > 0) begin
            wait_left--;
        end else if (rng[31:26] == 6'd2) begin
            wait_left = 4;
        end
        mmu_wait   = wait_left > 0;
        rng        = xorshift32(rng);
        n.pc       = {rng[31:2], 2'b00};
        rng        = xorshift32(rng);
        n.rs1_data = rng;
        rng        = xorshift32(rng);
        n.rs2_data = (rng[1:0] == 2'd0) ? n.rs1_data : rng;        // equal operands
        rng        = xorshift32(rng);
        n.imm      = (rng[2:0] == 3'd0) ? {rng[31:12], 12'd0} : rng;
        issue      = n;
    endtask

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    always @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            shadow <= bubble();
        end else if (flush || (stall && !mmu_wait)) begin
            shadow <= bubble();
        end else if (!mmu_wait) begin
            shadow <= issue;
        end
    end

    always @(negedge CLK) begin
        if (checking) begin
            want = exec_ref(shadow);
            check("exec_valid", 128'(exec_valid), 128'(want.valid));
            check("exec_pc", 128'(exec_pc), 128'(want.pc));
            check("reg_wr", 128'(reg_wr), 128'(want.rw));
            check("mem_rd", 128'(mem_rd), 128'(want.mr));
            check("mem_wr", 128'(mem_wr), 128'(want.mw));
            check("jmp", 128'(jmp), 128'(want.j));
            check("exc", 128'(exc), 128'(want.e));
        end
    end

    initial begin
        arst_n    = 1'b0;
        flush     = 1'b0;
        stall     = 1'b1;
        mmu_wait  = 1'b0;
        issue     = bubble();
        checking  = 1'b0;
        rng       = SEED;
        wait_left = 0;
        errors    = 0;
        repeat (2) @(negedge CLK);
        checking <= 1'b1;                           // reset state is the bubble
        repeat (RST_CYCLES - 2) @(negedge CLK);
        arst_n = 1'b1;
        repeat (3) @(negedge CLK);                  // stall bubbles after release
        for (int i = 0; i < N_CYCLES; i++) begin
            drive_random();
            @(negedge CLK);
        end
        @(posedge CLK);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #((RST_CYCLES + N_CYCLES + 50) * CLK_PERIOD);
        $display("timeout: the test sequence did not finish in time");
        $display("FAIL: see errors above");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: sim.f
rtl/exec_pkg.sv
rtl/exec_issue_reg.sv
rtl/exec_int_unit.sv
rtl/exec_lsu_addr.sv
rtl/exec_branch.sv
rtl/exec_trap.sv
rtl/exec_top.sv
verification/exec_props.sv
verification/tb_exec.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_exec
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

PASS_MSG := PASS: all tests

.PHONY: help test clean

help:
	@echo "make test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "test failed, see $(LOG)"; exit 1; }
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
